/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  // supported machine CSR addresses
  typedef enum logic [11:0] {
    addr_satp      = 12'h180,
    addr_mstatus   = 12'h300,
    addr_mtvec     = 12'h305,
    addr_mscratch  = 12'h340,
    addr_mepc      = 12'h341,
    addr_mcause    = 12'h342,
    addr_mvendorid = 12'hf11,
    addr_marchid   = 12'hf12
  } csr_addr_e;

  localparam logic [31:0] mstatus_reset = 32'h1800; // mpp = machine
  localparam logic [31:0] cause_ecall   = 32'd11;
  localparam logic [31:0] cause_timer   = 32'h80000007; // interrupt bit + code 7
  localparam logic [31:0] vendor_id     = 32'h79737978;
  localparam logic [31:0] arch_id       = 32'h015fdeeb;

  // trap kind from controller to CSR file
  localparam logic [1:0] trap_none = 2'd0;
  localparam logic [1:0] trap_exc  = 2'd1;
  localparam logic [1:0] trap_ret  = 2'd2;
  localparam logic [1:0] trap_intr = 2'd3;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] dnpc;
    logic [4:0]  gpr_waddr;
    logic [31:0] gpr_wdata;
    logic        zicsr;
    logic        exc;
    logic        ret;
    logic        fencei;
    logic [11:0] csr_waddr;
    logic [31:0] csr_wdata;
  } commit_t;

  typedef struct packed {
    logic        flush;
    logic [31:0] dnpc;
    logic        flush_icache;
    logic        flush_tlb;
  } redirect_t;

  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [18:0] upper;
      logic [1:0]  mpp;
      logic [2:0]  mid_hi;
      logic        mpie;
      logic [2:0]  mid_lo;
      logic        mie;
      logic [2:0]  lower;
    } fields;
  } mstatus_u;

endpackage

`default_nettype wire

/* hdl/apb_pkg.sv */
`default_nettype none

package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  // timer register offsets
  typedef enum logic [3:0] {
    mtime_lo    = 4'h0,
    mtime_hi    = 4'h4,
    mtimecmp_lo = 4'h8,
    mtimecmp_hi = 4'hc
  } timer_reg_e;

endpackage

`default_nettype wire

/* hdl/commit_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_ctrl (
  input  wire                  clock,
  input  wire                  reset,

  input  wire                  in_valid,
  input  wire csr_pkg::commit_t in_commit,
  output logic                 in_ready,

  output logic                 gpr_wen,
  output logic [4:0]           gpr_waddr,
  output logic [31:0]          gpr_wdata,

  input  wire                  mtip,
  input  wire                  csr_mie,
  input  wire [31:0]           csr_mtvec,
  input  wire [31:0]           csr_mepc,

  output logic                 csr_update,
  output csr_pkg::commit_t     csr_commit,
  output logic [1:0]           trap_kind,

  output csr_pkg::redirect_t   redirect
);

  import csr_pkg::*;

  typedef enum logic {
    st_run,
    st_flush
  } state_e;

  state_e      state;
  logic        accept;
  logic        plain;
  logic        take_intr;
  logic        satp_wr;
  logic        need_flush;
  logic [31:0] next_dnpc;

  assign in_ready = (state == st_run);
  assign accept   = in_valid & in_ready;

  // GPR write straight from the accepted commit
  assign gpr_wen   = accept;
  assign gpr_waddr = in_commit.gpr_waddr;
  assign gpr_wdata = in_commit.gpr_wdata;

  assign plain = ~(in_commit.zicsr | in_commit.exc | in_commit.ret | in_commit.fencei);
  assign take_intr = plain & mtip & csr_mie; // timer only on a plain commit

  assign satp_wr = in_commit.zicsr & ~in_commit.exc & ~in_commit.ret
                 & (in_commit.csr_waddr == addr_satp);

  assign need_flush = ~plain | take_intr;

  // classify, exception first
  always_comb begin
    if (in_commit.exc) begin
      trap_kind = trap_exc;
      next_dnpc = csr_mtvec;
    end else if (in_commit.ret) begin
      trap_kind = trap_ret;
      next_dnpc = csr_mepc;
    end else if (take_intr) begin
      trap_kind = trap_intr;
      next_dnpc = csr_mtvec; // mepc gets dnpc in the CSR file
    end else begin
      trap_kind = trap_none;
      next_dnpc = in_commit.pc + 32'd4;
    end
  end

  assign csr_update = accept;
  assign csr_commit = in_commit;

  always_ff @(posedge clock) begin
    redirect.dnpc <= next_dnpc;
    if (reset) begin
      state                 <= st_run;
      redirect.flush        <= 1'b0;
      redirect.flush_icache <= 1'b0;
      redirect.flush_tlb    <= 1'b0;
    end else begin
      redirect.flush        <= accept & need_flush;
      redirect.flush_icache <= accept & (in_commit.fencei | satp_wr);
      redirect.flush_tlb    <= accept & satp_wr;
      if (state == st_flush)
        state <= st_run; // flush lasts one cycle
      else if (accept && need_flush)
        state <= st_flush;
    end
  end

  // redirect pulse stalls the port for one cycle, then the port reopens
  a_flush_stall : assert property (
    @(posedge clock) disable iff (reset)
    redirect.flush |-> !in_ready ##1 (in_ready && !redirect.flush)
  );

endmodule

`default_nettype wire

/* hdl/machine_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module machine_timer #(
  parameter int unsigned timer_prescale = 4
) (
  input  wire                clock,
  input  wire                reset,
  input  wire apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t  apb_rsp,
  output logic               mtip
);

  import apb_pkg::*;

  localparam int unsigned pre_w = (timer_prescale > 1) ? $clog2(timer_prescale) : 1;
  localparam logic [pre_w-1:0] pre_last = pre_w'(timer_prescale - 1);

  logic [pre_w-1:0] pre_cnt;
  logic             tick;
  logic [63:0]      mtime;
  logic [63:0]      mtimecmp;
  logic             access;
  logic             wr_en;
  logic             mapped;

  assign tick   = (pre_cnt == pre_last);
  assign access = apb_req.psel & apb_req.penable;
  assign wr_en  = access & apb_req.pwrite;

  always_comb begin
    case (apb_req.paddr)
      mtime_lo, mtime_hi, mtimecmp_lo, mtimecmp_hi: mapped = 1'b1;
      default:                                      mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pre_cnt  <= '0;
      mtime    <= '0;
      mtimecmp <= '1; // no interrupt until software programs it
    end else begin
      pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
      if (tick)
        mtime <= mtime + 64'd1;
      if (wr_en) begin
        case (apb_req.paddr)
          mtime_lo:    mtime[31:0]     <= apb_req.pwdata; // write beats the tick
          mtime_hi:    mtime[63:32]    <= apb_req.pwdata;
          mtimecmp_lo: mtimecmp[31:0]  <= apb_req.pwdata;
          mtimecmp_hi: mtimecmp[63:32] <= apb_req.pwdata;
          default: ;
        endcase
      end
    end
  end

  assign mtip = (mtime >= mtimecmp);

  // read side, no wait states
  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access & ~mapped;
    case (apb_req.paddr)
      mtime_lo:    apb_rsp.prdata = mtime[31:0];
      mtime_hi:    apb_rsp.prdata = mtime[63:32];
      mtimecmp_lo: apb_rsp.prdata = mtimecmp[31:0];
      mtimecmp_hi: apb_rsp.prdata = mtimecmp[63:32];
      default:     apb_rsp.prdata = 32'd0;
    endcase
  end

  // a bad write leaves the compare alone
  a_slverr : assert property (
    @(posedge clock) disable iff (reset)
    apb_rsp.pslverr && apb_req.pwrite |=> $stable(mtimecmp)
  );

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_file (
  input  wire                   clock,
  input  wire                   reset,

  input  wire                   csr_update,
  input  wire csr_pkg::commit_t csr_commit,
  input  wire [1:0]             trap_kind,

  input  wire [11:0]            csr_raddr,
  output logic [31:0]           csr_rdata,

  output logic                  csr_mie,
  output logic [31:0]           csr_mtvec,
  output logic [31:0]           csr_mepc,
  output logic [31:0]           satp
);

  import csr_pkg::*;

  mstatus_u    mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [31:0] mscratch;

  logic        trap_take;
  logic        ret_take;
  logic        csr_wr;
  logic [11:0] waddr;
  logic [31:0] wdata;

  assign trap_take = csr_update & ((trap_kind == trap_exc) | (trap_kind == trap_intr));
  assign ret_take  = csr_update & (trap_kind == trap_ret);
  assign csr_wr    = csr_update & (trap_kind == trap_none) & csr_commit.zicsr;
  assign waddr     = csr_commit.csr_waddr;
  assign wdata     = csr_commit.csr_wdata;

  // mstatus and satp
  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus.raw <= mstatus_reset;
      satp        <= 32'd0;
    end else begin
      if (trap_take) begin
        mstatus.fields.mpie <= mstatus.fields.mie;
        mstatus.fields.mie  <= 1'b0;
      end else if (ret_take) begin
        mstatus.fields.mie  <= mstatus.fields.mpie;
        mstatus.fields.mpie <= 1'b1;
      end else if (csr_wr && waddr == addr_mstatus) begin
        mstatus.raw <= wdata;
      end
      if (csr_wr && waddr == addr_satp)
        satp <= wdata;
    end
  end

  // trap state and scratch
  always_ff @(posedge clock) begin
    if (trap_take) begin
      if (trap_kind == trap_intr) begin
        mepc   <= csr_commit.dnpc; // resume after the retired instruction
        mcause <= cause_timer;
      end else begin
        mepc   <= csr_commit.pc;
        mcause <= cause_ecall;
      end
    end else if (csr_wr) begin
      case (waddr)
        addr_mtvec:    mtvec    <= wdata;
        addr_mepc:     mepc     <= wdata;
        addr_mcause:   mcause   <= wdata;
        addr_mscratch: mscratch <= wdata;
        default: ; // read-only or unknown
      endcase
    end
  end

  always_comb begin
    case (csr_raddr)
      addr_mstatus:   csr_rdata = mstatus.raw;
      addr_mtvec:     csr_rdata = mtvec;
      addr_mepc:      csr_rdata = mepc;
      addr_mcause:    csr_rdata = mcause;
      addr_mscratch:  csr_rdata = mscratch;
      addr_satp:      csr_rdata = satp;
      addr_mvendorid: csr_rdata = vendor_id;
      addr_marchid:   csr_rdata = arch_id;
      default:        csr_rdata = 32'd0;
    endcase
  end

  assign csr_mie   = mstatus.fields.mie;
  assign csr_mtvec = mtvec;
  assign csr_mepc  = mepc;

  // exc together with ret is not a legal upstream encoding
  a_exc_ret : assert property (
    @(posedge clock) disable iff (reset)
    csr_update |-> !(csr_commit.exc && csr_commit.ret)
  );

endmodule

`default_nettype wire

/* hdl/writeback_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_unit #(
  parameter int unsigned timer_prescale = 4
) (
  input  wire                    clock,
  input  wire                    reset,

  // commit port from execute
  input  wire                    in_valid,
  input  wire csr_pkg::commit_t  in_commit,
  output logic                   in_ready,

  output logic                   gpr_wen,
  output logic [4:0]             gpr_waddr,
  output logic [31:0]            gpr_wdata,

  output csr_pkg::redirect_t     redirect,
  output logic [31:0]            satp,

  input  wire [11:0]             csr_raddr,
  output logic [31:0]            csr_rdata,

  // timer registers
  input  wire apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t      apb_rsp
);

  import csr_pkg::*;

  logic        csr_update;
  commit_t     csr_commit;
  logic [1:0]  trap_kind;
  logic        csr_mie;
  logic [31:0] csr_mtvec;
  logic [31:0] csr_mepc;
  logic        mtip;

  commit_ctrl i_commit_ctrl (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_commit  (in_commit),
    .in_ready   (in_ready),
    .gpr_wen    (gpr_wen),
    .gpr_waddr  (gpr_waddr),
    .gpr_wdata  (gpr_wdata),
    .mtip       (mtip),
    .csr_mie    (csr_mie),
    .csr_mtvec  (csr_mtvec),
    .csr_mepc   (csr_mepc),
    .csr_update (csr_update),
    .csr_commit (csr_commit),
    .trap_kind  (trap_kind),
    .redirect   (redirect)
  );

  csr_file i_csr_file (
    .clock      (clock),
    .reset      (reset),
    .csr_update (csr_update),
    .csr_commit (csr_commit),
    .trap_kind  (trap_kind),
    .csr_raddr  (csr_raddr),
    .csr_rdata  (csr_rdata),
    .csr_mie    (csr_mie),
    .csr_mtvec  (csr_mtvec),
    .csr_mepc   (csr_mepc),
    .satp       (satp)
  );

  machine_timer #(
    .timer_prescale (timer_prescale)
  ) i_machine_timer (
    .clock   (clock),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mtip    (mtip)
  );

endmodule

`default_nettype wire

/* sim/tb_vectors.svh */
function automatic void load_vectors();
  // commit: pc, rd, flags, csr addr, csr data, expected redirect
  // apb: kind, offset, write data or expected read data, expected pslverr, data checked
  // csr read: address, expected data
  add_csr_read(addr_mstatus, 32'h0000_1800);
  add_csr_read(addr_satp, 32'h0);
  add_apb(row_apb_rd, mtimecmp_hi, 32'hffff_ffff, 1'b0, 1'b1);
  // plain commits
  add_commit(32'h8000_0000, 5'd1, f_plain, 12'h0, 32'h0, no_redirect);
  add_commit(32'h8000_0004, 5'd2, f_plain, 12'h0, 32'h0, no_redirect);
  add_commit(32'h8000_0008, 5'd31, f_plain, 12'h0, 32'h0, no_redirect);
  // csr writes and reads
  add_commit(32'h8000_000c, 5'd3, f_csr, addr_mtvec, 32'h8000_0100,
             flush_to(32'h8000_0010, 1'b0, 1'b0));
  add_csr_read(addr_mtvec, 32'h8000_0100);
  add_commit(32'h8000_0010, 5'd4, f_csr, addr_mscratch, 32'hdead_beef,
             flush_to(32'h8000_0014, 1'b0, 1'b0));
  add_csr_read(addr_mscratch, 32'hdead_beef);
  add_commit(32'h8000_0014, 5'd5, f_csr, addr_satp, 32'h8000_1234,
             flush_to(32'h8000_0018, 1'b1, 1'b1));
  add_csr_read(addr_satp, 32'h8000_1234);
  add_csr_read(addr_mvendorid, vendor_id);
  add_csr_read(12'h7c0, 32'h0);
  // ecall with mie set beforehand
  add_commit(32'h8000_0018, 5'd6, f_csr, addr_mstatus, 32'h0000_1808,
             flush_to(32'h8000_001c, 1'b0, 1'b0));
  add_commit(32'h8000_0020, 5'd0, f_exc, 12'h0, 32'h0, flush_to(32'h8000_0100, 1'b0, 1'b0));
  add_csr_read(addr_mepc, 32'h8000_0020);
  add_csr_read(addr_mcause, 32'd11);
  add_csr_read(addr_mstatus, 32'h0000_1880);
  // mret back to mepc, then fence.i
  add_commit(32'h8000_0104, 5'd0, f_ret, 12'h0, 32'h0, flush_to(32'h8000_0020, 1'b0, 1'b0));
  add_csr_read(addr_mstatus, 32'h0000_1888);
  add_commit(32'h8000_0020, 5'd7, f_fencei, 12'h0, 32'h0,
             flush_to(32'h8000_0024, 1'b1, 1'b0));
  // timer registers
  add_apb(row_apb_wr, mtimecmp_lo, 32'h1234_5678, 1'b0, 1'b0);
  add_apb(row_apb_wr, mtimecmp_hi, 32'h9abc_def0, 1'b0, 1'b0);
  add_apb(row_apb_rd, mtimecmp_lo, 32'h1234_5678, 1'b0, 1'b1);
  add_apb(row_apb_rd, mtimecmp_hi, 32'h9abc_def0, 1'b0, 1'b1);
  add_apb(row_apb_rd, mtime_lo, 32'h0, 1'b0, 1'b0);
  add_apb(row_apb_rd, mtime_lo, 32'h0, 1'b0, 1'b0);
  add_apb(row_apb_rd, mtime_lo, 32'h0, 1'b0, 1'b0);
  add_apb(row_apb_wr, 4'h5, 32'h0, 1'b1, 1'b0);
  add_apb(row_apb_rd, 4'h5, 32'h0, 1'b1, 1'b0);
  add_apb(row_apb_rd, mtimecmp_lo, 32'h1234_5678, 1'b0, 1'b1);
  // timer interrupt, mtime restarts from 0 and compares at 40
  add_apb(row_apb_wr, mtime_lo, 32'h0, 1'b0, 1'b0);
  add_apb(row_apb_wr, mtime_hi, 32'h0, 1'b0, 1'b0);
  add_apb(row_apb_wr, mtimecmp_lo, 32'd40, 1'b0, 1'b0);
  add_apb(row_apb_wr, mtimecmp_hi, 32'h0, 1'b0, 1'b0);
  add_commit(32'h8000_0200, 5'd8, f_csr, addr_mstatus, 32'h0000_1808,
             flush_to(32'h8000_0204, 1'b0, 1'b0));
  add_intr_wait(32'h8000_0300, flush_to(32'h8000_0100, 1'b0, 1'b0));
  add_csr_read(addr_mcause, 32'h8000_0007);
  add_csr_read(addr_mstatus, 32'h0000_1880);
  // compare parked at all ones, mie back on, no interrupt
  add_apb(row_apb_wr, mtimecmp_hi, 32'hffff_ffff, 1'b0, 1'b0);
  add_apb(row_apb_wr, mtimecmp_lo, 32'hffff_ffff, 1'b0, 1'b0);
  add_commit(32'h8000_0400, 5'd9, f_csr, addr_mstatus, 32'h0000_1808,
             flush_to(32'h8000_0404, 1'b0, 1'b0));
  add_commit(32'h8000_0404, 5'd11, f_plain, 12'h0, 32'h0, no_redirect);
endfunction

/* sim/tb_writeback_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_writeback_unit;

  import csr_pkg::*;
  import apb_pkg::*;

  typedef enum logic [2:0] {
    row_commit,
    row_apb_wr,
    row_apb_rd,
    row_csr_rd,
    row_intr
  } row_kind_e;

  typedef struct packed {
    row_kind_e   kind;
    commit_t     commit;
    redirect_t   exp_redirect;
    logic [3:0]  paddr;
    logic [11:0] raddr;
    logic [31:0] data;     // apb write data or expected read data
    logic        exp_err;
    logic        chk_data; // clear on mtime reads
  } row_t;

  // commit flags {zicsr, exc, ret, fencei}
  localparam logic [3:0] f_plain  = 4'b0000;
  localparam logic [3:0] f_csr    = 4'b1000;
  localparam logic [3:0] f_exc    = 4'b0100;
  localparam logic [3:0] f_ret    = 4'b0010;
  localparam logic [3:0] f_fencei = 4'b0001;
  localparam redirect_t  no_redirect = '0;

  logic        clock = 1'b0;
  logic        reset;
  logic        in_valid;
  commit_t     in_commit;
  logic        in_ready;
  logic        gpr_wen;
  logic [4:0]  gpr_waddr;
  logic [31:0] gpr_wdata;
  redirect_t   redirect;
  logic [31:0] satp;
  logic [11:0] csr_raddr;
  logic [31:0] csr_rdata;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;

  row_t        rows[$];
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic [31:0] last_mtime = '0;

  writeback_unit #(
    .timer_prescale (4)
  ) i_writeback_unit (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_commit (in_commit),
    .in_ready  (in_ready),
    .gpr_wen   (gpr_wen),
    .gpr_waddr (gpr_waddr),
    .gpr_wdata (gpr_wdata),
    .redirect  (redirect),
    .satp      (satp),
    .csr_raddr (csr_raddr),
    .csr_rdata (csr_rdata),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic redirect_t flush_to(input logic [31:0] dnpc, input logic icache,
                                         input logic tlb);
    redirect_t r;
    r.flush        = 1'b1;
    r.dnpc         = dnpc;
    r.flush_icache = icache;
    r.flush_tlb    = tlb;
    return r;
  endfunction

  function automatic void add_commit(input logic [31:0] pc, input logic [4:0] rd,
                                     input logic [3:0] flags, input logic [11:0] caddr,
                                     input logic [31:0] cdata, input redirect_t exp);
    row_t r;
    r = '0;
    r.kind             = row_commit;
    r.commit.pc        = pc;
    r.commit.dnpc      = pc + 32'd4;
    r.commit.gpr_waddr = rd;
    {r.commit.zicsr, r.commit.exc, r.commit.ret, r.commit.fencei} = flags;
    r.commit.csr_waddr = caddr;
    r.commit.csr_wdata = cdata;
    r.exp_redirect     = exp;
    rows.push_back(r);
  endfunction

  function automatic void add_intr_wait(input logic [31:0] pc, input redirect_t exp);
    add_commit(pc, 5'd10, f_plain, 12'h0, 32'h0, exp);
    rows[rows.size() - 1].kind = row_intr;
  endfunction

  function automatic void add_apb(input row_kind_e kind, input logic [3:0] paddr,
                                  input logic [31:0] data, input logic exp_err,
                                  input logic chk_data);
    row_t r;
    r = '0;
    r.kind     = kind;
    r.paddr    = paddr;
    r.data     = data;
    r.exp_err  = exp_err;
    r.chk_data = chk_data;
    rows.push_back(r);
  endfunction

  function automatic void add_csr_read(input logic [11:0] raddr, input logic [31:0] exp);
    row_t r;
    r = '0;
    r.kind  = row_csr_rd;
    r.raddr = raddr;
    r.data  = exp;
    rows.push_back(r);
  endfunction

  `include "tb_vectors.svh"

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_gpr(input logic [4:0] got_addr, input logic [31:0] got_data,
                           input logic [4:0] exp_addr, input logic [31:0] exp_data);
    if (got_addr !== exp_addr) begin
      value_errors++;
      $display("Error at %0t ns: gpr_waddr = %0d, expected %0d", $time, got_addr, exp_addr);
    end
    check_word("gpr_wdata", got_data, exp_data);
  endtask

  // target only matters when a flush is expected
  task automatic check_redirect(input redirect_t got, input redirect_t exp);
    logic bad;
    if (exp.flush)
      bad = (got !== exp);
    else
      bad = ({got.flush, got.flush_icache, got.flush_tlb} !== 3'b000);
    if (bad) begin
      value_errors++;
      $display("Error at %0t ns: redirect = %h, expected %h", $time, got, exp);
    end
  endtask

  // one handshake, hands back the redirect of the following cycle
  task automatic send_commit(input commit_t c, output redirect_t seen);
    c.gpr_wdata = $urandom();
    in_commit   = c;
    in_valid    = 1'b1;
    do begin
      @(negedge clock);
    end while (!in_ready);
    check_bit("gpr_wen", gpr_wen, 1'b1);
    check_gpr(gpr_waddr, gpr_wdata, c.gpr_waddr, c.gpr_wdata);
    @(posedge clock);
    #1;
    in_valid = 1'b0;
    @(negedge clock);
    seen = redirect;
    if (redirect.flush)
      check_bit("in_ready", in_ready, 1'b0); // stalled while flushing
    @(posedge clock);
    #1;
  endtask

  task automatic apb_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] data, output apb_rsp_t rsp);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clock);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clock);
    rsp = apb_rsp;
    @(posedge clock);
    #1;
    apb_req = '0;
  endtask

  // plain commits until the timer fires, then mepc must hold that commit's dnpc
  task automatic wait_interrupt(input row_t r);
    commit_t   c;
    redirect_t seen;
    c    = r.commit;
    seen = '0;
    while (!seen.flush) begin
      send_commit(c, seen);
      if (!seen.flush) begin
        c.pc   = c.dnpc;
        c.dnpc = c.dnpc + 32'd4;
      end
    end
    check_redirect(seen, r.exp_redirect);
    csr_raddr = addr_mepc;
    @(negedge clock);
    check_word("mepc", csr_rdata, c.dnpc);
    @(posedge clock);
    #1;
  endtask

  initial begin
    row_t      r;
    redirect_t seen;
    apb_rsp_t  rsp;
    int        gap;
    void'($urandom(3371));
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_commit = '0;
    csr_raddr = '0;
    apb_req   = '0;
    load_vectors();
    cycle_limit = 40 * rows.size() + 2000;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    check_bit("in_ready", in_ready, 1'b1);
    check_bit("gpr_wen", gpr_wen, 1'b0);
    check_bit("redirect.flush", redirect.flush, 1'b0);
    check_bit("redirect.flush_icache", redirect.flush_icache, 1'b0);
    check_bit("redirect.flush_tlb", redirect.flush_tlb, 1'b0);
    check_bit("pslverr", apb_rsp.pslverr, 1'b0);
    @(posedge clock);
    #1;

    foreach (rows[i]) begin
      r = rows[i];
      case (r.kind)
        row_commit: begin
          send_commit(r.commit, seen);
          check_redirect(seen, r.exp_redirect);
        end
        row_apb_wr, row_apb_rd: begin
          apb_access(r.kind == row_apb_wr, r.paddr, r.data, rsp);
          check_bit("pslverr", rsp.pslverr, r.exp_err);
          check_bit("pready", rsp.pready, 1'b1); // no wait states
          if (r.kind == row_apb_rd && r.chk_data) begin
            check_word("prdata", rsp.prdata, r.data);
          end else if (r.kind == row_apb_rd && r.paddr == mtime_lo) begin
            if (rsp.prdata < last_mtime) begin
              other_errors++;
              $display("mtime went backwards from %h to %h at %0t ns",
                       last_mtime, rsp.prdata, $time);
            end
            last_mtime = rsp.prdata;
          end
        end
        row_csr_rd: begin
          csr_raddr = r.raddr;
          @(negedge clock);
          check_word("csr_rdata", csr_rdata, r.data);
          if (r.raddr == addr_satp)
            check_word("satp", satp, r.data); // MMU port follows the CSR
          @(posedge clock);
          #1;
        end
        row_intr: wait_interrupt(r);
      endcase
      gap = $urandom_range(2, 0);
      repeat (gap) begin
        @(posedge clock);
        #1;
      end
    end

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
hdl/csr_pkg.sv
hdl/apb_pkg.sv
hdl/commit_ctrl.sv
hdl/machine_timer.sv
hdl/csr_file.sv
hdl/writeback_unit.sv
sim/tb_writeback_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_writeback_unit -f project.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  exit 0
fi
exit 1
